//--- xbar_pkg.sv
`default_nettype none

package xbar_pkg;

	//////////////////////////////////////////////////
	// bus widths
	//////////////////////////////////////////////////
	parameter int addr_w = 32;
	parameter int data_w = 32;

	//////////////////////////////////////////////////
	// axi codes
	//////////////////////////////////////////////////
	parameter logic [1:0] resp_okay   = 2'b00;
	parameter logic [1:0] resp_slverr = 2'b10;

	parameter logic [1:0] burst_incr = 2'b01;
	parameter logic [2:0] size_word  = 3'b010; // 4 bytes

	// machine timer, counted whole, read out in halves
	typedef struct packed {
		logic [31:0] hi;
		logic [31:0] lo;
	} mtime_half_t;

	typedef union packed {
		logic [63:0] count;
		mtime_half_t half;
	} mtime_word_u;

endpackage

`default_nettype wire

//--- fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
	parameter int fetch_beats = 4
) (
	input  wire                          clock,
	input  wire                          rst_n,

	input  wire                          fetch_req,
	input  wire  [xbar_pkg::addr_w-1:0]  fetch_addr,
	output logic                         fetch_busy,
	output logic                         inst_valid,
	output logic [xbar_pkg::data_w-1:0]  inst_word,
	output logic                         inst_err,
	output logic                         fetch_done,

	output logic [xbar_pkg::addr_w-1:0]  ifu_araddr,
	output logic                         ifu_arvalid,
	output logic [3:0]                   ifu_arlen,
	output logic [1:0]                   ifu_arburst,
	input  wire                          ifu_arready,

	input  wire  [xbar_pkg::data_w-1:0]  ifu_rdata,
	input  wire  [1:0]                   ifu_rresp,
	input  wire                          ifu_rvalid,
	input  wire                          ifu_rlast,
	output logic                         ifu_rready
);

	localparam logic [1:0] st_idle = 2'd0;
	localparam logic [1:0] st_addr = 2'd1;
	localparam logic [1:0] st_data = 2'd2;

	localparam logic [3:0] last_beat = 4'(fetch_beats - 1);

	logic [1:0] state;
	logic [3:0] beat_cnt;
	logic       r_fire;

	assign r_fire = ifu_rvalid & ifu_rready;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state    <= st_idle;
			beat_cnt <= '0;
		end else begin
			case (state)
				st_idle: if (fetch_req) begin
					state    <= st_addr;
					beat_cnt <= '0;
				end
				st_addr: if (ifu_arready) state <= st_data;
				st_data: if (r_fire) begin
					beat_cnt <= beat_cnt + 4'd1;
					if (beat_cnt == last_beat) state <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

	// burst start address, held while arvalid is up
	always_ff @(posedge clock) begin
		if (state == st_idle && fetch_req) ifu_araddr <= fetch_addr;
	end

	assign ifu_arvalid = (state == st_addr);
	assign ifu_arlen   = last_beat;
	assign ifu_arburst = xbar_pkg::burst_incr;
	assign ifu_rready  = (state == st_data);

	assign fetch_busy = (state != st_idle);
	assign inst_valid = r_fire;
	assign inst_word  = ifu_rdata;
	assign inst_err   = (ifu_rresp != xbar_pkg::resp_okay);
	assign fetch_done = r_fire & (beat_cnt == last_beat);

	// slave must close the burst on the beat we counted
	a_rlast_on_count: assert property (@(posedge clock) disable iff (!rst_n)
		r_fire |-> (ifu_rlast == (beat_cnt == last_beat)));

endmodule

`default_nettype wire

//--- load_store_unit.sv
`timescale 1ns/1ps
`default_nettype none

module load_store_unit (
	input  wire                          clock,
	input  wire                          rst_n,

	input  wire                          mem_req,
	input  wire                          mem_we,
	input  wire  [xbar_pkg::addr_w-1:0]  mem_addr,
	input  wire  [xbar_pkg::data_w-1:0]  mem_wdata,
	input  wire  [3:0]                   mem_wstrb,
	output logic                         lsu_busy,
	output logic                         mem_done,
	output logic [xbar_pkg::data_w-1:0]  mem_rdata,
	output logic                         mem_err,

	output logic [xbar_pkg::addr_w-1:0]  lsu_araddr,
	output logic                         lsu_arvalid,
	output logic [2:0]                   lsu_arsize,
	input  wire                          lsu_arready,
	input  wire  [xbar_pkg::data_w-1:0]  lsu_rdata,
	input  wire  [1:0]                   lsu_rresp,
	input  wire                          lsu_rvalid,
	output logic                         lsu_rready,

	output logic [xbar_pkg::addr_w-1:0]  lsu_awaddr,
	output logic                         lsu_awvalid,
	output logic [2:0]                   lsu_awsize,
	input  wire                          lsu_awready,
	output logic [xbar_pkg::data_w-1:0]  lsu_wdata,
	output logic [3:0]                   lsu_wstrb,
	output logic                         lsu_wvalid,
	input  wire                          lsu_wready,
	input  wire  [1:0]                   lsu_bresp,
	input  wire                          lsu_bvalid,
	output logic                         lsu_bready
);

	localparam logic [1:0] st_idle  = 2'd0;
	localparam logic [1:0] st_read  = 2'd1;
	localparam logic [1:0] st_write = 2'd2;
	localparam logic [1:0] st_bresp = 2'd3;

	logic [1:0]                  state;
	logic                        aw_done, w_done;
	logic                        ar_sent;
	logic                        aw_fire, w_fire, r_fire, b_fire;
	logic [xbar_pkg::addr_w-1:0] addr_q;
	logic [xbar_pkg::data_w-1:0] rdata_q;

	assign aw_fire = lsu_awvalid & lsu_awready;
	assign w_fire  = lsu_wvalid & lsu_wready;
	assign r_fire  = lsu_rvalid & lsu_rready;
	assign b_fire  = lsu_bvalid & lsu_bready;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state   <= st_idle;
			aw_done <= 1'b0;
			w_done  <= 1'b0;
		end else begin
			case (state)
				st_idle: if (mem_req) begin
					state   <= mem_we ? st_write : st_read;
					aw_done <= 1'b0;
					w_done  <= 1'b0;
				end
				st_read: if (r_fire) state <= st_idle;
				st_write: begin
					aw_done <= aw_done | aw_fire;
					w_done  <= w_done | w_fire;
					// channels may finish in either order
					if ((aw_done | aw_fire) && (w_done | w_fire)) state <= st_bresp;
				end
				st_bresp: if (b_fire) state <= st_idle;
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == st_idle && mem_req) begin
			addr_q    <= mem_addr;
			lsu_wdata <= mem_wdata;
			lsu_wstrb <= mem_wstrb;
		end
		if (r_fire) rdata_q <= lsu_rdata;
	end

	assign lsu_araddr  = addr_q;
	assign lsu_arvalid = (state == st_read) & ~r_fire & ~ar_sent;
	assign lsu_arsize  = xbar_pkg::size_word;
	assign lsu_rready  = (state == st_read);

	assign lsu_awaddr  = addr_q;
	assign lsu_awvalid = (state == st_write) & ~aw_done;
	assign lsu_awsize  = xbar_pkg::size_word;
	assign lsu_wvalid  = (state == st_write) & ~w_done;
	assign lsu_bready  = (state == st_bresp);

	// ar only once per load
	always_ff @(posedge clock) begin
		if (!rst_n) ar_sent <= 1'b0;
		else if (state != st_read) ar_sent <= 1'b0;
		else if (lsu_arvalid && lsu_arready) ar_sent <= 1'b1;
	end

	assign lsu_busy  = (state != st_idle);
	assign mem_done  = r_fire | b_fire;
	assign mem_rdata = r_fire ? lsu_rdata : rdata_q;
	assign mem_err   = r_fire ? (lsu_rresp != xbar_pkg::resp_okay)
	                          : (b_fire & (lsu_bresp != xbar_pkg::resp_okay));

	// core must not issue while a transfer is open
	a_no_req_busy: assert property (@(posedge clock) disable iff (!rst_n)
		mem_req |-> !lsu_busy);

endmodule

`default_nettype wire

//--- bus_xbar.sv
`timescale 1ns/1ps
`default_nettype none

module bus_xbar #(
	parameter logic [31:0] clint_base = 32'h0200_0000,
	parameter logic [31:0] clint_size = 32'h0001_0000
) (
	input  wire         clock,
	input  wire         rst_n,

	input  wire  [31:0] ifu_araddr,
	input  wire         ifu_arvalid,
	input  wire  [3:0]  ifu_arlen,
	input  wire  [1:0]  ifu_arburst,
	output logic        ifu_arready,
	output logic [31:0] ifu_rdata,
	output logic [1:0]  ifu_rresp,
	output logic        ifu_rvalid,
	output logic        ifu_rlast,
	input  wire         ifu_rready,

	input  wire  [31:0] lsu_araddr,
	input  wire         lsu_arvalid,
	input  wire  [2:0]  lsu_arsize,
	output logic        lsu_arready,
	output logic [31:0] lsu_rdata,
	output logic [1:0]  lsu_rresp,
	output logic        lsu_rvalid,
	input  wire         lsu_rready,
	input  wire  [31:0] lsu_awaddr,
	input  wire         lsu_awvalid,
	input  wire  [2:0]  lsu_awsize,
	output logic        lsu_awready,
	input  wire  [31:0] lsu_wdata,
	input  wire  [3:0]  lsu_wstrb,
	input  wire         lsu_wvalid,
	output logic        lsu_wready,
	output logic [1:0]  lsu_bresp,
	output logic        lsu_bvalid,
	input  wire         lsu_bready,

	input  wire         io_master_awready,
	output logic        io_master_awvalid,
	output logic [31:0] io_master_awaddr,
	output logic [3:0]  io_master_awid,
	output logic [7:0]  io_master_awlen,
	output logic [2:0]  io_master_awsize,
	output logic [1:0]  io_master_awburst,
	input  wire         io_master_wready,
	output logic        io_master_wvalid,
	output logic [31:0] io_master_wdata,
	output logic [3:0]  io_master_wstrb,
	output logic        io_master_wlast,
	output logic        io_master_bready,
	input  wire         io_master_bvalid,
	input  wire  [1:0]  io_master_bresp,
	input  wire  [3:0]  io_master_bid,
	input  wire         io_master_arready,
	output logic        io_master_arvalid,
	output logic [31:0] io_master_araddr,
	output logic [3:0]  io_master_arid,
	output logic [7:0]  io_master_arlen,
	output logic [2:0]  io_master_arsize,
	output logic [1:0]  io_master_arburst,
	output logic        io_master_rready,
	input  wire         io_master_rvalid,
	input  wire  [1:0]  io_master_rresp,
	input  wire  [31:0] io_master_rdata,
	input  wire         io_master_rlast,
	input  wire  [3:0]  io_master_rid,

	output logic [31:0] clint_araddr,
	output logic        clint_arvalid,
	input  wire         clint_arready,
	input  wire  [31:0] clint_rdata,
	input  wire  [1:0]  clint_rresp,
	input  wire         clint_rvalid,
	output logic        clint_rready
);

	localparam logic [1:0] own_idle  = 2'd0;
	localparam logic [1:0] own_fetch = 2'd1;
	localparam logic [1:0] own_load  = 2'd2;

	logic [1:0] owner;
	logic       clint_sel; // latched at grant
	logic       in_window;
	logic       is_fetch, is_load, to_soc, to_clint;

	assign in_window = (lsu_araddr >= clint_base) && ((lsu_araddr - clint_base) < clint_size);

	//////////////////////////////////////////////////
	// read owner
	//////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			owner     <= own_idle;
			clint_sel <= 1'b0;
		end else begin
			case (owner)
				own_idle: if (ifu_arvalid) begin
					owner <= own_fetch; // fetch has priority
				end else if (lsu_arvalid) begin
					owner     <= own_load;
					clint_sel <= in_window;
				end
				own_fetch: if (ifu_rvalid && ifu_rready && ifu_rlast) owner <= own_idle;
				own_load:  if (lsu_rvalid && lsu_rready) owner <= own_idle;
				default:   owner <= own_idle;
			endcase
		end
	end

	assign is_fetch = (owner == own_fetch);
	assign is_load  = (owner == own_load);
	assign to_soc   = is_load & ~clint_sel;
	assign to_clint = is_load & clint_sel;

	//////////////////////////////////////////////////
	// read steering
	//////////////////////////////////////////////////
	assign io_master_arvalid = (is_fetch & ifu_arvalid) | (to_soc & lsu_arvalid);
	assign io_master_araddr  = is_fetch ? ifu_araddr : lsu_araddr;
	assign io_master_arid    = 4'd0;
	assign io_master_arlen   = is_fetch ? {4'd0, ifu_arlen} : 8'd0;
	assign io_master_arsize  = is_fetch ? xbar_pkg::size_word : lsu_arsize;
	assign io_master_arburst = is_fetch ? ifu_arburst : xbar_pkg::burst_incr;
	assign io_master_rready  = (is_fetch & ifu_rready) | (to_soc & lsu_rready);

	assign clint_arvalid = to_clint & lsu_arvalid;
	assign clint_araddr  = lsu_araddr;
	assign clint_rready  = to_clint & lsu_rready;

	assign ifu_arready = is_fetch & io_master_arready;
	assign ifu_rvalid  = is_fetch & io_master_rvalid;
	assign ifu_rdata   = io_master_rdata;
	assign ifu_rresp   = io_master_rresp;
	assign ifu_rlast   = is_fetch & io_master_rlast;

	assign lsu_arready = to_soc ? io_master_arready : (to_clint & clint_arready);
	assign lsu_rvalid  = to_soc ? io_master_rvalid : (to_clint & clint_rvalid);
	assign lsu_rdata   = clint_sel ? clint_rdata : io_master_rdata;
	assign lsu_rresp   = clint_sel ? clint_rresp : io_master_rresp;

	// writes go straight out, single beat
	assign io_master_awvalid = lsu_awvalid;
	assign io_master_awaddr  = lsu_awaddr;
	assign io_master_awid    = 4'd0;
	assign io_master_awlen   = 8'd0;
	assign io_master_awsize  = lsu_awsize;
	assign io_master_awburst = xbar_pkg::burst_incr;
	assign lsu_awready       = io_master_awready;
	assign io_master_wvalid  = lsu_wvalid;
	assign io_master_wdata   = lsu_wdata;
	assign io_master_wstrb   = lsu_wstrb;
	assign io_master_wlast   = lsu_wvalid;
	assign lsu_wready        = io_master_wready;
	assign io_master_bready  = lsu_bready;
	assign lsu_bvalid        = io_master_bvalid;
	assign lsu_bresp         = io_master_bresp;

	a_one_ar_target: assert property (@(posedge clock) disable iff (!rst_n)
		!(io_master_arvalid && clint_arvalid));

	a_resp_to_owner: assert property (@(posedge clock) disable iff (!rst_n)
		(ifu_rvalid |-> owner == own_fetch) and (lsu_rvalid |-> owner == own_load));

	// ids are never anything but zero here
	a_zero_ids: assert property (@(posedge clock) disable iff (!rst_n)
		(io_master_rvalid |-> io_master_rid == 4'd0) and
		(io_master_bvalid |-> io_master_bid == 4'd0));

endmodule

`default_nettype wire

//--- clint.sv
`timescale 1ns/1ps
`default_nettype none

module clint (
	input  wire                          clock,
	input  wire                          rst_n,

	input  wire  [xbar_pkg::addr_w-1:0]  araddr,
	input  wire                          arvalid,
	output logic                         arready,

	output logic [xbar_pkg::data_w-1:0]  rdata,
	output logic [1:0]                   rresp,
	output logic                         rvalid,
	input  wire                          rready
);

	xbar_pkg::mtime_word_u mtime;
	logic                  ar_fire;
	logic [15:0]           offset; // within the 64 KiB window

	assign ar_fire = arvalid & arready;
	assign offset  = araddr[15:0];

	always_ff @(posedge clock) begin
		if (!rst_n) mtime.count <= 64'd0;
		else        mtime.count <= mtime.count + 64'd1;
	end

	always_ff @(posedge clock) begin
		if (!rst_n) rvalid <= 1'b0;
		else if (ar_fire) rvalid <= 1'b1;
		else if (rready) rvalid <= 1'b0; // held until taken
	end

	// snapshot taken at the ar beat
	always_ff @(posedge clock) begin
		if (ar_fire) begin
			case (offset)
				16'h0000: begin
					rdata <= mtime.half.lo;
					rresp <= xbar_pkg::resp_okay;
				end
				16'h0004: begin
					rdata <= mtime.half.hi;
					rresp <= xbar_pkg::resp_okay;
				end
				default: begin
					rdata <= '0;
					rresp <= xbar_pkg::resp_slverr;
				end
			endcase
		end
	end

	assign arready = ~rvalid;

endmodule

`default_nettype wire

//--- mem_subsystem_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_top #(
	parameter logic [31:0] clint_base  = 32'h0200_0000,
	parameter logic [31:0] clint_size  = 32'h0001_0000,
	parameter int          fetch_beats = 4
) (
	input  wire         clock,
	input  wire         rst_n,

	// fetch side
	input  wire         fetch_req,
	input  wire  [31:0] fetch_addr,
	output logic        fetch_busy,
	output logic        inst_valid,
	output logic [31:0] inst_word,
	output logic        inst_err,
	output logic        fetch_done,

	// load/store side
	input  wire         mem_req,
	input  wire         mem_we,
	input  wire  [31:0] mem_addr,
	input  wire  [31:0] mem_wdata,
	input  wire  [3:0]  mem_wstrb,
	output logic        lsu_busy,
	output logic        mem_done,
	output logic [31:0] mem_rdata,
	output logic        mem_err,

	// external master
	input  wire         io_master_awready,
	output logic        io_master_awvalid,
	output logic [31:0] io_master_awaddr,
	output logic [3:0]  io_master_awid,
	output logic [7:0]  io_master_awlen,
	output logic [2:0]  io_master_awsize,
	output logic [1:0]  io_master_awburst,
	input  wire         io_master_wready,
	output logic        io_master_wvalid,
	output logic [31:0] io_master_wdata,
	output logic [3:0]  io_master_wstrb,
	output logic        io_master_wlast,
	output logic        io_master_bready,
	input  wire         io_master_bvalid,
	input  wire  [1:0]  io_master_bresp,
	input  wire  [3:0]  io_master_bid,
	input  wire         io_master_arready,
	output logic        io_master_arvalid,
	output logic [31:0] io_master_araddr,
	output logic [3:0]  io_master_arid,
	output logic [7:0]  io_master_arlen,
	output logic [2:0]  io_master_arsize,
	output logic [1:0]  io_master_arburst,
	output logic        io_master_rready,
	input  wire         io_master_rvalid,
	input  wire  [1:0]  io_master_rresp,
	input  wire  [31:0] io_master_rdata,
	input  wire         io_master_rlast,
	input  wire  [3:0]  io_master_rid
);

	wire [31:0] ifu_araddr, ifu_rdata;
	wire [3:0]  ifu_arlen;
	wire [1:0]  ifu_arburst, ifu_rresp;
	wire        ifu_arvalid, ifu_arready, ifu_rvalid, ifu_rlast, ifu_rready;

	wire [31:0] lsu_araddr, lsu_rdata, lsu_awaddr, lsu_wdata;
	wire [2:0]  lsu_arsize, lsu_awsize;
	wire [3:0]  lsu_wstrb;
	wire [1:0]  lsu_rresp, lsu_bresp;
	wire        lsu_arvalid, lsu_arready, lsu_rvalid, lsu_rready;
	wire        lsu_awvalid, lsu_awready, lsu_wvalid, lsu_wready;
	wire        lsu_bvalid, lsu_bready;

	wire [31:0] clint_araddr, clint_rdata;
	wire [1:0]  clint_rresp;
	wire        clint_arvalid, clint_arready, clint_rvalid, clint_rready;

	fetch_unit #(.fetch_beats(fetch_beats)) u_fetch (.*);

	load_store_unit u_lsu (.*);

	bus_xbar #(
		.clint_base(clint_base),
		.clint_size(clint_size)
	) u_xbar (.*);

	clint u_clint (
		.clock   (clock),
		.rst_n   (rst_n),
		.araddr  (clint_araddr),
		.arvalid (clint_arvalid),
		.arready (clint_arready),
		.rdata   (clint_rdata),
		.rresp   (clint_rresp),
		.rvalid  (clint_rvalid),
		.rready  (clint_rready)
	);

endmodule

`default_nettype wire

//--- tb_soc_memory.sv
`timescale 1ns/1ps
`default_nettype none

module tb_soc_memory (
	input  wire         clock,
	input  wire         rst_n,
	input  wire         ar_hold, // stall bits, one per channel
	input  wire         w_hold,

	output logic        io_master_awready,
	input  wire         io_master_awvalid,
	input  wire  [31:0] io_master_awaddr,
	output logic        io_master_wready,
	input  wire         io_master_wvalid,
	input  wire  [31:0] io_master_wdata,
	input  wire  [3:0]  io_master_wstrb,
	input  wire         io_master_bready,
	output logic        io_master_bvalid,
	output logic [1:0]  io_master_bresp,
	output logic [3:0]  io_master_bid,
	output logic        io_master_arready,
	input  wire         io_master_arvalid,
	input  wire  [31:0] io_master_araddr,
	input  wire  [7:0]  io_master_arlen,
	input  wire         io_master_rready,
	output logic        io_master_rvalid,
	output logic [1:0]  io_master_rresp,
	output logic [31:0] io_master_rdata,
	output logic        io_master_rlast,
	output logic [3:0]  io_master_rid
);

	logic [31:0] written [logic [29:0]]; // only words stored over the bus
	logic        rd_valid = 1'b0;
	logic        rd_last = 1'b0;
	logic [1:0]  rd_resp = 2'b00;
	logic [31:0] rd_data = 32'd0;
	logic [31:0] rd_addr;
	logic [7:0]  rd_left;
	logic        b_valid = 1'b0;
	logic [1:0]  b_resp = 2'b00;
	logic        aw_got, w_got;
	logic [31:0] aw_addr, w_data;
	logic [3:0]  w_strb;

	function automatic logic [31:0] word_at(input logic [31:0] addr);
		if (written.exists(addr[31:2])) return written[addr[31:2]];
		return {addr[31:2], 2'b00} ^ 32'h5a5a_0000;
	endfunction

	function automatic logic [1:0] resp_for(input logic [31:0] addr);
		return (addr >= 32'h8000_0000) ? xbar_pkg::resp_slverr : xbar_pkg::resp_okay;
	endfunction

	function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
			input logic [3:0] strb);
		logic [31:0] word;
		word = old;
		for (int i = 0; i < 4; i++)
			if (strb[i]) word[8*i +: 8] = data[8*i +: 8];
		return word;
	endfunction

	assign io_master_arready = rst_n & ~rd_valid & ~ar_hold;
	assign io_master_rvalid  = rd_valid;
	assign io_master_rdata   = rd_data;
	assign io_master_rresp   = rd_resp;
	assign io_master_rlast   = rd_last;
	assign io_master_rid     = 4'd0;
	assign io_master_awready = rst_n & ~aw_got & ~b_valid;
	assign io_master_wready  = rst_n & ~w_got & ~b_valid & ~w_hold;
	assign io_master_bvalid  = b_valid;
	assign io_master_bresp   = b_resp;
	assign io_master_bid     = 4'd0;

	always @(posedge clock) begin
		if (!rst_n) begin
			rd_valid <= 1'b0;
			b_valid  <= 1'b0;
			aw_got   <= 1'b0;
			w_got    <= 1'b0;
		end else begin
			// read side, one burst at a time
			if (io_master_arvalid && io_master_arready) begin
				rd_valid <= 1'b1;
				rd_addr  <= io_master_araddr;
				rd_left  <= io_master_arlen;
				rd_data  <= word_at(io_master_araddr);
				rd_resp  <= resp_for(io_master_araddr);
				rd_last  <= (io_master_arlen == 8'd0);
			end else if (rd_valid && io_master_rready) begin
				if (rd_last) begin
					rd_valid <= 1'b0;
				end else begin
					rd_addr <= rd_addr + 32'd4;
					rd_left <= rd_left - 8'd1;
					rd_data <= word_at(rd_addr + 32'd4);
					rd_resp <= resp_for(rd_addr + 32'd4);
					rd_last <= (rd_left == 8'd1);
				end
			end

			// write side, aw and w in any order
			if (io_master_awvalid && io_master_awready) begin
				aw_got  <= 1'b1;
				aw_addr <= io_master_awaddr;
			end
			if (io_master_wvalid && io_master_wready) begin
				w_got  <= 1'b1;
				w_data <= io_master_wdata;
				w_strb <= io_master_wstrb;
			end
			if (aw_got && w_got && !b_valid) begin
				if (resp_for(aw_addr) == xbar_pkg::resp_okay)
					written[aw_addr[31:2]] = merge_bytes(word_at(aw_addr), w_data, w_strb);
				b_valid <= 1'b1;
				b_resp  <= resp_for(aw_addr);
				aw_got  <= 1'b0;
				w_got   <= 1'b0;
			end else if (b_valid && io_master_bready) begin
				b_valid <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- tb_mem_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsystem;

	localparam int          fetch_beats = 4;
	localparam logic [31:0] clint_base  = 32'h0200_0000;
	localparam logic [31:0] clint_size  = 32'h0001_0000;
	localparam int          max_wait    = 400; // cycles per entry
	localparam int          n_entries   = 17;

	localparam logic [1:0] k_fetch = 2'd0;
	localparam logic [1:0] k_load  = 2'd1;
	localparam logic [1:0] k_store = 2'd2;
	localparam logic [1:0] k_both  = 2'd3;

	typedef struct packed {
		logic [1:0]  kind;
		logic [31:0] addr;
		logic [31:0] addr2; // load address for kind both
		logic [31:0] wdata;
		logic [3:0]  wstrb;
		logic        exp_err;
	} entry_t;

	logic        clock = 1'b0;
	logic        rst_n;
	logic        fetch_req, mem_req, mem_we;
	logic [31:0] fetch_addr, mem_addr, mem_wdata;
	logic [3:0]  mem_wstrb;
	logic        ar_hold = 1'b0;
	logic        w_hold = 1'b0;
	logic [31:0] lfsr_state = 32'h8714c4b5;

	wire         fetch_busy, inst_valid, inst_err, fetch_done;
	wire  [31:0] inst_word;
	wire         lsu_busy, mem_done, mem_err;
	wire  [31:0] mem_rdata;

	wire         io_master_awready, io_master_awvalid, io_master_wready, io_master_wvalid;
	wire         io_master_wlast, io_master_bready, io_master_bvalid;
	wire         io_master_arready, io_master_arvalid, io_master_rready, io_master_rvalid;
	wire         io_master_rlast;
	wire  [31:0] io_master_awaddr, io_master_wdata, io_master_araddr, io_master_rdata;
	wire  [7:0]  io_master_awlen, io_master_arlen;
	wire  [3:0]  io_master_awid, io_master_wstrb, io_master_bid;
	wire  [3:0]  io_master_arid, io_master_rid;
	wire  [2:0]  io_master_awsize, io_master_arsize;
	wire  [1:0]  io_master_awburst, io_master_bresp, io_master_arburst, io_master_rresp;

	entry_t      stim [n_entries];
	logic [31:0] model [logic [29:0]]; // expected memory after stores
	logic [31:0] last_lo;
	logic        have_lo = 1'b0;

	mem_subsystem_top #(
		.clint_base  (clint_base),
		.clint_size  (clint_size),
		.fetch_beats (fetch_beats)
	) u_dut (.*);

	tb_soc_memory u_mem (.*);

	always #20 clock = ~clock;

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0]; // x^32 + x^22 + x^2 + x + 1
		return {s[30:0], fb};
	endfunction

	function automatic logic [31:0] expected_word(input logic [31:0] addr);
		if (model.exists(addr[31:2])) return model[addr[31:2]];
		return {addr[31:2], 2'b00} ^ 32'h5a5a_0000;
	endfunction

	function automatic logic [31:0] strobe_merge(input logic [31:0] old, input logic [31:0] data,
			input logic [3:0] strb);
		logic [31:0] mask;
		mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
		return (old & ~mask) | (data & mask);
	endfunction

	task automatic expect_eq(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("MISMATCH at %0d ns: %s got %h expected %h", $time, name, got, exp);
			$display("Checks failed");
			$fatal(1);
		end
	endtask

	// ready stalls for the slave memory
	always @(posedge clock) begin
		#2;
		lfsr_state = lfsr_step(lfsr_state);
		ar_hold = lfsr_state[0];
		lfsr_state = lfsr_step(lfsr_state);
		w_hold = lfsr_state[0];
	end

	// side fields of each external handshake
	always @(negedge clock) begin
		if (rst_n && io_master_awvalid && io_master_awready) begin
			expect_eq("io_master_awid", 32'(io_master_awid), 32'd0);
			expect_eq("io_master_awlen", 32'(io_master_awlen), 32'd0);
			expect_eq("io_master_awsize", 32'(io_master_awsize), 32'd2); // 4 bytes
			expect_eq("io_master_awburst", 32'(io_master_awburst), 32'd1); // incr
		end
		if (rst_n && io_master_wvalid && io_master_wready)
			expect_eq("io_master_wlast", 32'(io_master_wlast), 32'd1);
		if (rst_n && io_master_arvalid && io_master_arready) begin
			expect_eq("io_master_arid", 32'(io_master_arid), 32'd0);
			expect_eq("io_master_arsize", 32'(io_master_arsize), 32'd2);
			expect_eq("io_master_arburst", 32'(io_master_arburst), 32'd1);
		end
	end

	//////////////////////////////////////////////////
	// stimulus table
	//////////////////////////////////////////////////
	task automatic fill_table();
		stim[0]  = '{k_fetch, 32'h0000_1000, 32'h0, 32'h0, 4'h0, 1'b0};
		stim[1]  = '{k_load,  32'h0000_2040, 32'h0, 32'h0, 4'h0, 1'b0};
		stim[2]  = '{k_store, 32'h0000_2040, 32'h0, 32'ha1b2_c3d4, 4'b0110, 1'b0};
		stim[3]  = '{k_load,  32'h0000_2040, 32'h0, 32'h0, 4'h0, 1'b0}; // partial merge
		stim[4]  = '{k_load,  32'h0200_0000, 32'h0, 32'h0, 4'h0, 1'b0}; // mtime lo
		stim[5]  = '{k_load,  32'h0200_0000, 32'h0, 32'h0, 4'h0, 1'b0};
		stim[6]  = '{k_load,  32'h0200_0004, 32'h0, 32'h0, 4'h0, 1'b0}; // mtime hi
		stim[7]  = '{k_load,  32'h0200_0008, 32'h0, 32'h0, 4'h0, 1'b1};
		stim[8]  = '{k_both,  32'h0000_2038, 32'h0000_2040, 32'h0, 4'h0, 1'b0};
		stim[9]  = '{k_load,  32'h8000_0010, 32'h0, 32'h0, 4'h0, 1'b1};
		stim[10] = '{k_load,  32'h0000_0ff0, 32'h0, 32'h0, 4'h0, 1'b0};
		stim[11] = '{k_store, 32'h8000_0000, 32'h0, 32'h1111_2222, 4'hf, 1'b1};
		stim[12] = '{k_store, 32'h0000_0ff0, 32'h0, 32'h1357_9bdf, 4'hf, 1'b0};
		stim[13] = '{k_load,  32'h0000_0ff0, 32'h0, 32'h0, 4'h0, 1'b0};
		stim[14] = '{k_store, 32'h0000_2044, 32'h0, 32'hdead_beef, 4'b1001, 1'b0};
		stim[15] = '{k_fetch, 32'h0000_2040, 32'h0, 32'h0, 4'h0, 1'b0};
		stim[16] = '{k_both,  32'h0000_4000, 32'h0200_0000, 32'h0, 4'h0, 1'b0};
	endtask

	task automatic check_load(input logic [31:0] addr, input logic [31:0] data,
			input logic exp_err);
		logic [31:0] offset;
		offset = addr - clint_base;
		if (addr >= clint_base && offset < clint_size) begin
			if (offset == 32'd0) begin
				if (have_lo) expect_eq("clint lo increasing", 32'(data > last_lo), 32'd1);
				last_lo = data;
				have_lo = 1'b1;
			end else if (offset == 32'd4) begin
				expect_eq("clint hi", data, 32'd0);
			end else begin
				expect_eq("clint bad offset data", data, 32'd0);
			end
		end else if (!exp_err) begin
			expect_eq("mem_rdata", data, expected_word(addr));
		end
	endtask

	task automatic run_entry(input int idx);
		entry_t      e;
		logic        want_fetch, want_mem, inst_bad, got_err;
		logic [31:0] ld_addr, got_rdata;
		logic [31:0] inst_seen [16];
		int          cycles, n_inst, inst_at_done, fetch_cycle, mem_cycle;
		e = stim[idx];
		want_fetch = (e.kind == k_fetch) || (e.kind == k_both);
		want_mem   = (e.kind != k_fetch);
		ld_addr    = (e.kind == k_both) ? e.addr2 : e.addr;
		inst_bad   = 1'b0;
		got_err    = 1'b0;
		got_rdata  = 32'd0;
		n_inst       = 0;
		inst_at_done = 0;
		fetch_cycle  = -1;
		mem_cycle    = -1;
		cycles       = 0;

		@(posedge clock);
		#2;
		expect_eq("fetch_busy before request", 32'(fetch_busy), 32'd0);
		expect_eq("lsu_busy before request", 32'(lsu_busy), 32'd0);
		fetch_req  = want_fetch;
		fetch_addr = e.addr;
		mem_req    = want_mem;
		mem_we     = (e.kind == k_store);
		mem_addr   = ld_addr;
		mem_wdata  = e.wdata;
		mem_wstrb  = e.wstrb;
		@(posedge clock);
		#2;
		fetch_req = 1'b0;
		mem_req   = 1'b0;

		while (((want_fetch && fetch_cycle < 0) || (want_mem && mem_cycle < 0))
				&& cycles < max_wait) begin
			@(negedge clock);
			cycles++;
			// busy up to and including the done cycle
			expect_eq("fetch_busy", 32'(fetch_busy), 32'(want_fetch && fetch_cycle < 0));
			expect_eq("lsu_busy", 32'(lsu_busy), 32'(want_mem && mem_cycle < 0));
			if (inst_valid && n_inst < 16) begin
				inst_seen[n_inst] = inst_word;
				inst_bad = inst_bad | inst_err;
				n_inst++;
			end
			if (fetch_done) begin
				fetch_cycle  = cycles;
				inst_at_done = n_inst;
			end
			if (mem_done) begin
				mem_cycle = cycles;
				got_rdata = mem_rdata;
				got_err   = mem_err;
			end
		end
		if ((want_fetch && fetch_cycle < 0) || (want_mem && mem_cycle < 0)) begin
			$display("timeout at %0d ns: entry %0d never signalled done", $time, idx);
			$display("Checks failed");
			$fatal(1);
		end

		if (want_fetch) begin
			expect_eq("fetch beat count", 32'(n_inst), 32'(fetch_beats));
			expect_eq("fetch_done beat", 32'(inst_at_done), 32'(fetch_beats));
			expect_eq("inst_err", 32'(inst_bad), 32'd0);
			for (int i = 0; i < fetch_beats; i++)
				expect_eq("inst_word", inst_seen[i], expected_word(e.addr + 32'(4 * i)));
		end
		if (want_mem) begin
			expect_eq("mem_err", 32'(got_err), 32'(e.exp_err));
			if (e.kind == k_store) begin
				if (!e.exp_err)
					model[ld_addr[31:2]] = strobe_merge(expected_word(ld_addr), e.wdata, e.wstrb);
			end else begin
				check_load(ld_addr, got_rdata, e.exp_err);
			end
		end
		if (e.kind == k_both)
			expect_eq("fetch before load", 32'(fetch_cycle < mem_cycle), 32'd1);
	endtask

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////
	initial begin
		rst_n      = 1'b0;
		fetch_req  = 1'b0;
		fetch_addr = 32'd0;
		mem_req    = 1'b0;
		mem_we     = 1'b0;
		mem_addr   = 32'd0;
		mem_wdata  = 32'd0;
		mem_wstrb  = 4'd0;
		last_lo    = 32'd0;
		fill_table();
		repeat (3) @(posedge clock);
		#2;
		rst_n = 1'b1;
		for (int i = 0; i < n_entries; i++)
			run_entry(i);
		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- all.f
xbar_pkg.sv
fetch_unit.sv
load_store_unit.sv
bus_xbar.sv
clint.sv
mem_subsystem_top.sv
tb_soc_memory.sv
tb_mem_subsystem.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := tb_mem_subsystem
FILELIST  := all.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0 --top-module $(TOP)

SOURCES   := $(shell cat $(FILELIST))
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
